// File: include/des_cfg.svh
`ifndef DES_CFG_SVH
`define DES_CFG_SVH

// **************************************************
// DES round widths
// **************************************************

// Data block and raw key.
`define DES_BLOCK_W 64

// One Feistel half.
`define DES_HALF_W 32

// Subkey and expanded right half.
`define DES_SUBKEY_W 48

`define DES_CD_W 28 // C or D after PC-1.

// Cumulative left rotation of C and D.
`define DES_ROT_W 5

`define DES_SBOX_COUNT 8

`endif

// File: verilog/des_types_pkg.sv
`include "des_cfg.svh"

package des_types_pkg;

    // Bit 1 is the MSB, as in the cipher tables.
    typedef logic [1:`DES_BLOCK_W] block_t;

    typedef logic [1:`DES_HALF_W] half_t;

    typedef logic [1:`DES_SUBKEY_W] subkey_t;

    typedef logic [1:`DES_CD_W] cd_t;

    // Legal range 0 to 27.
    typedef logic [`DES_ROT_W-1:0] rot_t;

    typedef logic [1:`DES_HALF_W/`DES_SBOX_COUNT] nibble_t; // One S-box output.

endpackage

// File: verilog/des_tables_pkg.sv
`include "des_cfg.svh"

package des_tables_pkg;

    import des_types_pkg::*;

    // **************************************************
    // S-boxes, one nibble per entry, row major
    // **************************************************

    localparam logic [255:0] SBOX_TABLE [`DES_SBOX_COUNT] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    // **************************************************
    // Bit selection tables, 1-based source indices
    // **************************************************

    localparam int unsigned E_TABLE [`DES_SUBKEY_W] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int unsigned P_TABLE [`DES_HALF_W] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int unsigned PC1_C_TABLE [`DES_CD_W] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36
    };

    localparam int unsigned PC1_D_TABLE [`DES_CD_W] = '{
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int unsigned PC2_TABLE [`DES_SUBKEY_W] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // **************************************************
    // Lookup and permutation functions
    // **************************************************

    function automatic nibble_t sbox_lookup(int unsigned box, logic [1:6] din);
        logic [5:0] idx;
        idx = {din[1], din[6], din[2:5]}; // Row from outer bits, column from the middle.
        return SBOX_TABLE[box][255 - 4*idx -: 4];
    endfunction

    function automatic subkey_t expand(half_t r);
        subkey_t e;
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            e[i+1] = r[E_TABLE[i]];
        end
        return e;
    endfunction

    function automatic half_t permute_p(half_t s);
        half_t p;
        for (int i = 0; i < `DES_HALF_W; i++)
        begin
            p[i+1] = s[P_TABLE[i]];
        end
        return p;
    endfunction

    function automatic cd_t pc1_c(block_t key);
        cd_t c;
        for (int i = 0; i < `DES_CD_W; i++)
        begin
            c[i+1] = key[PC1_C_TABLE[i]];
        end
        return c;
    endfunction

    function automatic cd_t pc1_d(block_t key);
        cd_t d;
        for (int i = 0; i < `DES_CD_W; i++)
        begin
            d[i+1] = key[PC1_D_TABLE[i]];
        end
        return d;
    endfunction

    function automatic subkey_t pc2(cd_t c, cd_t d);
        logic [1:2*`DES_CD_W] cd;
        subkey_t k;
        cd = {c, d};
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            k[i+1] = cd[PC2_TABLE[i]];
        end
        return k;
    endfunction

    // Bit 1 is the MSB, so a left shift moves toward bit 1.
    function automatic cd_t rotate_cd(cd_t x, rot_t r);
        return (x << r) | (x >> (`DES_CD_W - r));
    endfunction

endpackage

// File: verilog/key_schedule.sv
module key_schedule (
    input  logic                   clk,
    input  logic                   rst,
    input  des_types_pkg::block_t  key_in,
    input  des_types_pkg::rot_t    rotation,
    output des_types_pkg::subkey_t subkey
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    cd_t c_q;
    cd_t d_q;

    // Stage 1 holds the rotated C and D halves.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            c_q <= '0;
            d_q <= '0;
        end
        else
        begin
            c_q <= rotate_cd(pc1_c(key_in), rotation);
            d_q <= rotate_cd(pc1_d(key_in), rotation);
        end
    end

    // Stage 2 lines up with the expansion register of the data path.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            subkey <= '0;
        end
        else
        begin
            subkey <= pc2(c_q, d_q);
        end
    end

endmodule

// File: verilog/expand_mix.sv
`include "des_cfg.svh"

module expand_mix (
    input  logic                   clk,
    input  logic                   rst,
    input  des_types_pkg::block_t  in,
    input  des_types_pkg::subkey_t subkey,
    output des_types_pkg::subkey_t mixed,
    output des_types_pkg::half_t   left,
    output des_types_pkg::half_t   right
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    half_t   left_0;
    half_t   right_0;
    half_t   left_1;
    half_t   right_1;
    subkey_t expanded;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            left_0   <= '0;
            right_0  <= '0;
            expanded <= '0;
            left_1   <= '0;
            right_1  <= '0;
            mixed    <= '0;
            left     <= '0;
            right    <= '0;
        end
        else
        begin
            left_0  <= in[1:`DES_HALF_W]; // Capture.
            right_0 <= in[`DES_HALF_W+1:`DES_BLOCK_W];

            expanded <= expand(right_0);
            left_1   <= left_0;
            right_1  <= right_0;

            // Subkey from the same input cycle arrives here.
            mixed <= expanded ^ subkey;
            left  <= left_1;
            right <= right_1;
        end
    end

endmodule

// File: verilog/sbox_layer.sv
`include "des_cfg.svh"

module sbox_layer (
    input  logic                   clk,
    input  logic                   rst,
    input  des_types_pkg::subkey_t mixed,
    input  des_types_pkg::half_t   left,
    input  des_types_pkg::half_t   right,
    output des_types_pkg::half_t   substituted,
    output des_types_pkg::half_t   left_q,
    output des_types_pkg::half_t   right_q
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    localparam int GROUP_W = `DES_SUBKEY_W / `DES_SBOX_COUNT;
    localparam int NIB_W   = $bits(nibble_t);

    half_t sub_next;

    // Group i feeds S-box i+1.
    always_comb
    begin
        for (int i = 0; i < `DES_SBOX_COUNT; i++)
        begin
            sub_next[NIB_W*i+1 +: NIB_W] = sbox_lookup(i, mixed[GROUP_W*i+1 +: GROUP_W]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            substituted <= '0;
            left_q      <= '0;
            right_q     <= '0;
        end
        else
        begin
            substituted <= sub_next;
            left_q      <= left;
            right_q     <= right;
        end
    end

endmodule

// File: verilog/permute_combine.sv
module permute_combine (
    input  logic                  clk,
    input  logic                  rst,
    input  des_types_pkg::half_t  substituted,
    input  des_types_pkg::half_t  left,
    input  des_types_pkg::half_t  right,
    output des_types_pkg::block_t out
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    half_t permuted;
    half_t left_q;
    half_t right_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            permuted <= '0;
            left_q   <= '0;
            right_q  <= '0;
        end
        else
        begin
            permuted <= permute_p(substituted);
            left_q   <= left;
            right_q  <= right;
        end
    end

    // New left is the old right. New right is f XOR the old left.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out <= '0;
        end
        else
        begin
            out <= {right_q, left_q ^ permuted};
        end
    end

endmodule

// File: verilog/des_round_top.sv
module des_round_top (
    input  logic                  clk,
    input  logic                  rst,
    input  des_types_pkg::block_t in,
    input  des_types_pkg::block_t key_in,
    input  des_types_pkg::rot_t   rotation,
    output des_types_pkg::block_t out
);

    import des_types_pkg::*;

    subkey_t subkey;
    subkey_t mixed;
    half_t   left_mix;
    half_t   right_mix;
    half_t   substituted;
    half_t   left_sub;
    half_t   right_sub;

    // **************************************************
    // Key path
    // **************************************************

    key_schedule u_key_schedule (
        .clk      (clk),
        .rst      (rst),
        .key_in   (key_in),
        .rotation (rotation),
        .subkey   (subkey)
    );

    // **************************************************
    // Data path
    // **************************************************

    expand_mix u_expand_mix (
        .clk    (clk),
        .rst    (rst),
        .in     (in),
        .subkey (subkey),
        .mixed  (mixed),
        .left   (left_mix),
        .right  (right_mix)
    );

    sbox_layer u_sbox_layer (
        .clk         (clk),
        .rst         (rst),
        .mixed       (mixed),
        .left        (left_mix),
        .right       (right_mix),
        .substituted (substituted),
        .left_q      (left_sub),
        .right_q     (right_sub)
    );

    permute_combine u_permute_combine (
        .clk         (clk),
        .rst         (rst),
        .substituted (substituted),
        .left        (left_sub),
        .right       (right_sub),
        .out         (out)
    );

endmodule

// File: verification/des_round_assertions.sv
`include "des_cfg.svh"

module des_round_checker (
    input logic                  clk,
    input logic                  rst,
    input des_types_pkg::block_t in,
    input des_types_pkg::block_t key_in,
    input des_types_pkg::rot_t   rotation,
    input des_types_pkg::block_t out
);

    timeunit 1ns;
    timeprecision 10ps;

    import des_types_pkg::*;
    import des_tables_pkg::*;

    localparam block_t KAT_IN  = 64'hCC00CCFFF0AAF0AA;
    localparam block_t KAT_KEY = 64'h133457799BBCDFF1;
    localparam block_t KAT_OUT = 64'hF0AAF0AAEF4A6544;

    event check_failed;

    int unsigned hist; // Rising edges since reset was released.

    // **************************************************
    // Reference round model
    // **************************************************

    function automatic block_t round_model(block_t blk, block_t key, rot_t rot);
        cd_t         c;
        cd_t         d;
        cd_t         c_rot;
        cd_t         d_rot;
        logic [1:56] cd;
        subkey_t     k;
        subkey_t     e;
        half_t       s;
        half_t       f;
        logic [5:0]  six;
        int unsigned entry;
        for (int i = 0; i < `DES_CD_W; i++)
        begin
            c[i+1] = key[PC1_C_TABLE[i]];
            d[i+1] = key[PC1_D_TABLE[i]];
        end
        for (int i = 0; i < `DES_CD_W; i++)
        begin
            c_rot[i+1] = c[((i + int'(rot)) % `DES_CD_W) + 1];
            d_rot[i+1] = d[((i + int'(rot)) % `DES_CD_W) + 1];
        end
        cd = {c_rot, d_rot};
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            k[i+1] = cd[PC2_TABLE[i]];
            e[i+1] = blk[`DES_HALF_W + E_TABLE[i]]; // E on the right half.
        end
        e = e ^ k;
        for (int b = 0; b < `DES_SBOX_COUNT; b++)
        begin
            six   = e[6*b+1 +: 6];
            entry = (2 * six[5] + six[0]) * 16 + six[4:1];
            s[4*b+1 +: 4] = SBOX_TABLE[b][255 - 4*entry -: 4];
        end
        for (int i = 0; i < `DES_HALF_W; i++)
        begin
            f[i+1] = s[P_TABLE[i]];
        end
        return {blk[`DES_HALF_W+1:`DES_BLOCK_W], blk[1:`DES_HALF_W] ^ f};
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hist <= 0;
        end
        else if (hist < 7)
        begin
            hist <= hist + 1;
        end
    end

    // **************************************************
    // Properties
    // **************************************************

    a_reset_clear: assert property (@(posedge clk) $fell(rst) |-> out == '0)
    else
    begin
        $error("** Error at %0t: out not zero after reset, got %h", $time, out);
        -> check_failed;
    end

    a_known_answer: assert property (@(posedge clk) disable iff (rst)
        (hist >= 6 && $past(in, 6) == KAT_IN && $past(key_in, 6) == KAT_KEY
            && $past(rotation, 6) == 5'd1) |-> out == KAT_OUT)
    else
    begin
        $error("** Error at %0t: known answer mismatch, got %h", $time, out);
        -> check_failed;
    end

    a_round_model: assert property (@(posedge clk) disable iff (rst)
        hist >= 6 |-> out == round_model($past(in, 6), $past(key_in, 6), $past(rotation, 6)))
    else
    begin
        $error("** Error at %0t: round result %h differs from model", $time, out);
        -> check_failed;
    end

    a_swap: assert property (@(posedge clk) disable iff (rst)
        hist >= 6 |-> out[1:`DES_HALF_W] == $past(in[`DES_HALF_W+1:`DES_BLOCK_W], 6))
    else
    begin
        $error("** Error at %0t: left half of out is not the old right half", $time);
        -> check_failed;
    end

    a_rotation_legal: assert property (@(posedge clk) !rst |-> rotation <= 5'd27)
    else
    begin
        $error("** Error at %0t: illegal rotation %0d", $time, rotation);
        -> check_failed;
    end

endmodule

bind des_round_top des_round_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .in       (in),
    .key_in   (key_in),
    .rotation (rotation),
    .out      (out)
);

// File: verification/des_round_tb.sv
module des_round_tb;

    timeunit 1ns;
    timeprecision 10ps;

    import des_types_pkg::*;

    localparam int RANDOM_ITEMS = 200;
    localparam int DRAIN_CYCLES = 6;
    localparam int MAX_CYCLES   = 400; // Run takes about 215 cycles.

    logic        clk;
    logic        rst;
    block_t      in;
    block_t      key_in;
    rot_t        rotation;
    block_t      out;
    logic [31:0] lcg_state;
    int unsigned cycle_count;

    des_round_top UUT (
        .clk      (clk),
        .rst      (rst),
        .in       (in),
        .key_in   (key_in),
        .rotation (rotation),
        .out      (out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // Random stimulus
    // **************************************************

    function automatic logic [31:0] next_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic block_t random_block();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_word();
        lo = next_word();
        return {hi, lo};
    endfunction

    function automatic rot_t random_rotation();
        logic [31:0] w;
        w = next_word();
        return rot_t'((w >> 8) % 28); // Upper bits, range 0 to 27.
    endfunction

    // Values go out on a falling edge and are held for one cycle.
    task automatic apply_item(input block_t blk, input block_t key, input rot_t rot);
        in       = blk;
        key_in   = key;
        rotation = rot;
        @(negedge clk);
    endtask

    // **************************************************
    // Main sequence
    // **************************************************

    initial
    begin
        rst       = 1'b1;
        in        = '0;
        key_in    = '0;
        rotation  = '0;
        lcg_state = 32'h09ef5481;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apply_item(64'hCC00CCFFF0AAF0AA, 64'h133457799BBCDFF1, 5'd1);

        // Both ends of the rotation range.
        apply_item(random_block(), random_block(), 5'd0);
        apply_item(random_block(), random_block(), 5'd27);

        for (int i = 0; i < RANDOM_ITEMS; i++)
        begin
            apply_item(random_block(), random_block(), random_rotation());
        end

        repeat (DRAIN_CYCLES) @(negedge clk);

        $display("TEST PASS");
        $finish;
    end

    // Any assertion in the checker raises this event.
    initial
    begin
        @(UUT.u_checker.check_failed);
        $display("TEST FAIL");
        $fatal(1, "Assertion failure reported by des_round_checker");
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("TEST FAIL");
        $fatal(1, "Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    end

endmodule

// File: project.f
+incdir+include
verilog/des_types_pkg.sv
verilog/des_tables_pkg.sv
verilog/key_schedule.sv
verilog/expand_mix.sv
verilog/sbox_layer.sv
verilog/permute_combine.sv
verilog/des_round_top.sv
verification/des_round_assertions.sv
verification/des_round_tb.sv

// File: Bender.yml
package:
  name: des_round

sources:
  - include_dirs:
      - include
    files:
      - verilog/des_types_pkg.sv
      - verilog/des_tables_pkg.sv
      - verilog/key_schedule.sv
      - verilog/expand_mix.sv
      - verilog/sbox_layer.sv
      - verilog/permute_combine.sv
      - verilog/des_round_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/des_round_assertions.sv
      - verification/des_round_tb.sv
